//--- flist.f
rtl/rvPipePkg.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/branchPredictor.sv
rtl/pipeDatapath.sv
rtl/pipeControl.sv
rtl/rvPipeCore.sv
dv/coreAsserts_asserts.sv
dv/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= coreTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/coreTb.sv
`timescale 1ns/1ns

module coreTb;

    localparam int progLen = 24;
    localparam int numTests = 6;
    localparam int watchdogCycles = numTests * progLen * 20;
    localparam int kAdd = 0, kSub = 1, kAnd = 2, kOr = 3, kSlt = 4, kAddi = 5, kAndi = 6;
    localparam int kOri = 7, kLw = 8, kSw = 9, kBeq = 10, kBne = 11, kJal = 12;
    localparam int kJalr = 13, kLui = 14;

    logic clk, reset, active;
    rvPipePkg::word_t imemAddr, imemData, dmemRdata;
    rvPipePkg::memReq_t dmemReq;
    rvPipePkg::retire_t retire;

    rvPipePkg::word_t imem [256];
    rvPipePkg::word_t dmem [64];
    rvPipePkg::word_t memModel [64];
    int kindA [64], rdA [64], rs1A [64], rs2A [64], immA [64];
    int pos, testId, cycle, errors, checks;
    logic [31:0] lcgState;
    logic [36:0] expWr [$];
    logic [63:0] expSt [$];
    int loopTimes [$];

    rvPipeCore DUT (
        .clk(clk), .reset(reset),
        .imemAddr_o(imemAddr), .imemData_i(imemData),
        .dmemReq_o(dmemReq), .dmemRdata_i(dmemRdata), .retire_o(retire)
    );

    assign imemData = imem[imemAddr[9:2]];
    assign dmemRdata = dmem[dmemReq.addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (dmemReq.we) begin
            dmem[dmemReq.addr[7:2]] <= dmemReq.wdata;
        end
    end

    function automatic int rndRange(int k);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return int'((lcgState >> 8) % k);
    endfunction

    function automatic int minOf(int a, int b);
        return (a < b) ? a : b;
    endfunction

    // Fill depends on every address bit.
    function automatic rvPipePkg::word_t fillWord(int a, int t);
        return (a * 32'h9e37_79b9) ^ (t << 24) ^ 32'h0f1e_2d3c;
    endfunction

    task automatic put(int k, int rd, int rs1, int rs2, int imm);
        kindA[pos] = k;
        rdA[pos] = rd;
        rs1A[pos] = rs1;
        rs2A[pos] = rs2;
        immA[pos] = imm;
        pos++;
    endtask

    task automatic randAlu();
        int k;
        k = rndRange(8);
        if (k < 5) put(k, 1 + rndRange(7), rndRange(8), rndRange(8), 0);
        else put(k, 1 + rndRange(7), rndRange(8), 0, rndRange(4096) - 2048);
    endtask

    function automatic rvPipePkg::word_t encode(int i);
        logic [31:0] im;
        logic [4:0] rd, r1, r2;
        im = immA[i];
        rd = rdA[i];
        r1 = rs1A[i];
        r2 = rs2A[i];
        case (kindA[i])
            kAdd:  return {7'h00, r2, r1, 3'b000, rd, 7'b0110011};
            kSub:  return {7'h20, r2, r1, 3'b000, rd, 7'b0110011};
            kAnd:  return {7'h00, r2, r1, 3'b111, rd, 7'b0110011};
            kOr:   return {7'h00, r2, r1, 3'b110, rd, 7'b0110011};
            kSlt:  return {7'h00, r2, r1, 3'b010, rd, 7'b0110011};
            kAddi: return {im[11:0], r1, 3'b000, rd, 7'b0010011};
            kAndi: return {im[11:0], r1, 3'b111, rd, 7'b0010011};
            kOri:  return {im[11:0], r1, 3'b110, rd, 7'b0010011};
            kLw:   return {im[11:0], r1, 3'b010, rd, 7'b0000011};
            kSw:   return {im[11:5], r2, r1, 3'b010, im[4:0], 7'b0100011};
            kBeq:  return {im[12], im[10:5], r2, r1, 3'b000, im[4:1], im[11], 7'b1100011};
            kBne:  return {im[12], im[10:5], r2, r1, 3'b001, im[4:1], im[11], 7'b1100011};
            kJal:  return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};
            kJalr: return {im[11:0], r1, 3'b000, rd, 7'b1100111};
            default: return {im[31:12], rd, 7'b0110111};
        endcase
    endfunction

    task automatic genProgram(int t);
        int r, k;
        pos = 0;
        if (t == 5) begin
            put(kAddi, 5, 0, 0, 12);
            put(kAddi, 8, 8, 0, 3); // Loop marker write.
            put(kAddi, 5, 5, 0, -1);
            put(kBne, 0, 5, 0, -8);
        end
        while (pos < progLen - 1) begin
            r = rndRange(3);
            if (t == 2 && r == 1) begin
                put(kSw, 0, 0, 1 + rndRange(7), rndRange(64) * 4);
            end else if (t == 2 && r == 2 && pos < progLen - 2) begin
                k = 1 + rndRange(7);
                put(kLw, k, 0, 0, rndRange(64) * 4);
                put(kAdd, 1 + rndRange(7), k, rndRange(8), 0);
            end else if (t == 3 && r == 0) begin
                k = rndRange(8);
                put(kBeq + rndRange(2), 0, k, rndRange(2) ? k : rndRange(8),
                    (1 + rndRange(minOf(4, progLen - 1 - pos))) * 4);
            end else if (t == 3 && r == 1) begin
                put(kSw, 0, 0, 1 + rndRange(7), rndRange(64) * 4);
            end else if (t == 4 && r == 0 && pos < progLen - 2) begin
                put(kLui, rndRange(8), 0, 0, int'(lcgState & 32'hffff_f000));
                put(kJal, rndRange(8), 0, 0, (1 + rndRange(minOf(3, progLen - 1 - pos))) * 4);
            end else if (t == 4 && r == 1 && pos < progLen - 3) begin
                k = pos + 2 + rndRange(minOf(3, progLen - pos - 2));
                put(kAddi, 7, 0, 0, k * 4 + rndRange(2)); // Low bit gets cleared.
                put(kJalr, rndRange(8), 7, 0, 0);
            end else begin
                randAlu();
                if (t == 6 && rndRange(2) == 1) rdA[pos-1] = 0;
                if (t == 6 && rndRange(2) == 1) rs1A[pos-1] = 0;
            end
        end
        put(kJal, 0, 0, 0, 0); // Spin in place.
    endtask

    // ISA reference model over the field arrays.
    task automatic runModel();
        rvPipePkg::word_t m [32];
        rvPipePkg::word_t a, b, res, addr;
        int idx, next, steps;
        logic wr;
        for (int i = 0; i < 32; i++) m[i] = '0;
        idx = 0;
        for (steps = 0; steps < 1000; steps++) begin
            if (kindA[idx] == kJal && immA[idx] == 0) break;
            a = m[rs1A[idx]];
            b = m[rs2A[idx]];
            addr = a + immA[idx];
            next = idx + 1;
            wr = 1'b1;
            case (kindA[idx])
                kAdd: res = a + b;
                kSub: res = a - b;
                kAnd: res = a & b;
                kOr:  res = a | b;
                kSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                kAddi: res = addr;
                kAndi: res = a & immA[idx];
                kOri: res = a | immA[idx];
                kLw: res = memModel[addr[7:2]];
                kSw: begin
                    wr = 1'b0;
                    memModel[addr[7:2]] = b;
                    expSt.push_back({addr, b});
                end
                kBeq, kBne: begin
                    wr = 1'b0;
                    if ((a == b) == (kindA[idx] == kBeq)) next = idx + immA[idx] / 4;
                end
                kJal: begin
                    res = idx * 4 + 4;
                    next = idx + immA[idx] / 4;
                end
                kJalr: begin
                    res = idx * 4 + 4;
                    next = int'(addr >> 2);
                end
                default: res = immA[idx];
            endcase
            if (wr && rdA[idx] != 0) begin
                m[rdA[idx]] = res;
                expWr.push_back({5'(rdA[idx]), res});
            end
            idx = next;
        end
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (active && retire.valid) begin
            checks++;
            assert (retire.rd != '0) else begin
                $display("Retire strobe for a write to x0");
                errors++;
            end
            if (testId == 5 && retire.rd == 5'd8) loopTimes.push_back(cycle);
            if (expWr.size() == 0) begin
                $display("Unexpected retire of x%0d after the program ended", retire.rd);
                errors++;
            end else begin
                checkValue("retire_o.rd", 32'(retire.rd), 32'(expWr[0][36:32]));
                checkValue("retire_o.data", retire.data, expWr[0][31:0]);
                void'(expWr.pop_front());
            end
        end
        if (active && dmemReq.we) begin
            if (expSt.size() == 0) begin
                $display("Unexpected store to address %h", dmemReq.addr);
                errors++;
            end else begin
                checkValue("dmemReq_o.addr", dmemReq.addr, expSt[0][63:32]);
                checkValue("dmemReq_o.wdata", dmemReq.wdata, expSt[0][31:0]);
                void'(expSt.pop_front());
            end
        end
    end

    task automatic runTest(int t, string name);
        int errBefore, firstGap, lastGap;
        errBefore = errors;
        testId = t;
        genProgram(t);
        for (int i = 0; i < 256; i++) imem[i] = (i < pos) ? encode(i) : '0;
        @(posedge clk);
        #1 reset = 1'b1;
        active = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        checkValue("imemAddr_o", imemAddr, 32'h0000_0000); // Reset PC.
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= fillWord(i, t);
            memModel[i] = fillWord(i, t);
        end
        expWr.delete();
        expSt.delete();
        loopTimes.delete();
        runModel();
        reset = 1'b0;
        active = 1'b1;
        while (expWr.size() > 0 || expSt.size() > 0) @(posedge clk);
        repeat (8) @(posedge clk);
        #1 active = 1'b0;
        if (t == 5) begin
            checks++;
            firstGap = (loopTimes.size() == 12) ? loopTimes[1] - loopTimes[0] : 0;
            lastGap = (loopTimes.size() == 12) ? loopTimes[11] - loopTimes[10] : 0;
            assert (loopTimes.size() == 12 && lastGap < firstGap) else begin
                $display("Predictor did not shorten the loop: first gap %0d, last gap %0d",
                         firstGap, lastGap);
                errors++;
            end
        end
        $display("Test %0d %s: %s", t, name, (errors == errBefore) ? "ok" : "errors");
    endtask

    initial begin
        #(watchdogCycles * 20);
        $display("Timeout: the core stopped retiring before the programs finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        active = 1'b0;
        errors = 0;
        checks = 0;
        testId = 0;
        lcgState = 32'hf575_c6da;
        runTest(1, "alu forwarding");
        runTest(2, "load use and stores");
        runTest(3, "forward branches");
        runTest(4, "jal jalr lui");
        runTest(5, "counted loop");
        runTest(6, "x0 writes and reads");
        $display("Tests: %0d, checks: %0d, errors: %0d", numTests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dv/coreAsserts_asserts.sv
`timescale 1ns/1ns

module coreAsserts (
    input logic                   clk,
    input logic                   reset,
    input rvPipePkg::hazardCtrl_t hazard,
    input logic                   pcSrc
);

    // A redirect and a load-use stall never start together.
    flushStallApart: assert property (@(posedge clk) disable iff (reset)
        !($rose(hazard.flushD) && $rose(hazard.stallD)))
        else $error("flushD and stallD rose in the same cycle");

    stallOneCycle: assert property (@(posedge clk) disable iff (reset)
        hazard.stallD |=> !hazard.stallD)
        else $error("stallD held for more than one cycle");

    // First cycle out of reset is quiet.
    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> !(hazard.stallF || hazard.stallD || hazard.flushD
                           || hazard.flushE || pcSrc))
        else $error("hazard or redirect active right after reset");

endmodule

bind pipeControl coreAsserts asserts (
    .clk(clk), .reset(reset), .hazard(hazard_o), .pcSrc(ctrl_o.pcSrc)
);

//--- rtl/rvPipeCore.sv
`timescale 1ns/1ns

module rvPipeCore (
    input  logic                clk,
    input  logic                reset,
    output rvPipePkg::word_t    imemAddr_o,
    input  rvPipePkg::word_t    imemData_i,
    output rvPipePkg::memReq_t  dmemReq_o,
    input  rvPipePkg::word_t    dmemRdata_i,
    output rvPipePkg::retire_t  retire_o
);

    rvPipePkg::decodeFields_t decodeFields;
    rvPipePkg::hazardCtrl_t hazard;
    rvPipePkg::execCtrl_t execCtrl;
    rvPipePkg::regAddr_t rs1E, rs2E, rdE, rdM, rdW;
    logic zeroE;
    logic predTaken;

    pipeControl control (
        .clk(clk), .reset(reset),
        .decode_i(decodeFields),
        .rs1E_i(rs1E), .rs2E_i(rs2E), .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW),
        .zeroE_i(zeroE), .predTakenD_i(predTaken),
        .hazard_o(hazard), .ctrl_o(execCtrl)
    );

    pipeDatapath datapath (
        .clk(clk), .reset(reset),
        .instrF_i(imemData_i), .pcF_o(imemAddr_o),
        .hazard_i(hazard), .ctrl_i(execCtrl), .decode_o(decodeFields),
        .rs1E_o(rs1E), .rs2E_o(rs2E), .rdE_o(rdE), .rdM_o(rdM), .rdW_o(rdW),
        .zeroE_o(zeroE),
        .dmemReq_o(dmemReq_o), .dmemRdata_i(dmemRdata_i),
        .retire_o(retire_o), .predTakenF_o(predTaken)
    );

endmodule

//--- rtl/pipeControl.sv
`timescale 1ns/1ns

module pipeControl (
    input  logic                     clk,
    input  logic                     reset,
    input  rvPipePkg::decodeFields_t decode_i,
    input  rvPipePkg::regAddr_t      rs1E_i,
    input  rvPipePkg::regAddr_t      rs2E_i,
    input  rvPipePkg::regAddr_t      rdE_i,
    input  rvPipePkg::regAddr_t      rdM_i,
    input  rvPipePkg::regAddr_t      rdW_i,
    input  logic                     zeroE_i,
    input  logic                     predTakenD_i,
    output rvPipePkg::hazardCtrl_t   hazard_o,
    output rvPipePkg::execCtrl_t     ctrl_o
);

    typedef struct packed {
        logic                  regWrite;
        rvPipePkg::resultSrc_t resultSrc;
        rvPipePkg::aluCtrl_t   aluCtrl;
        logic                  aluSrcImm;
        logic                  isBranch;
        logic                  isJump;
        logic                  bne;
    } stageCtrl_t;

    stageCtrl_t ctrlD, ctrlE;
    rvPipePkg::immSrc_t immSrcD;
    rvPipePkg::aluCtrl_t aluF;
    rvPipePkg::resultSrc_t resultSrcM, resultSrcW;
    logic regWriteM, regWriteW, predD, predE, takenE, pcSrcE, loadUse;

    function automatic rvPipePkg::fwdSel_t fwdSel(rvPipePkg::regAddr_t rs,
            rvPipePkg::regAddr_t rdM, logic wrM, rvPipePkg::regAddr_t rdW, logic wrW);
        if (rs != '0 && rs == rdM && wrM) return rvPipePkg::fwdMem;
        if (rs != '0 && rs == rdW && wrW) return rvPipePkg::fwdWb;
        return rvPipePkg::fwdNone;
    endfunction

    always_comb begin
        case (decode_i.funct3)
            3'b000:  aluF = (decode_i.op == rvPipePkg::opReg && decode_i.funct7b5)
                          ? rvPipePkg::aluSub : rvPipePkg::aluAdd;
            3'b010:  aluF = rvPipePkg::aluSlt;
            3'b110:  aluF = rvPipePkg::aluOr;
            3'b111:  aluF = rvPipePkg::aluAnd;
            default: aluF = rvPipePkg::aluAdd;
        endcase
    end

    // Decoder. Anything unlisted stays all-zero, a no-op.
    always_comb begin
        ctrlD = '0;
        immSrcD = rvPipePkg::immI;
        case (decode_i.op)
            rvPipePkg::opReg: begin
                ctrlD.aluCtrl = aluF;
                ctrlD.regWrite = decode_i.funct3 inside {3'b000, 3'b010, 3'b110, 3'b111};
            end
            rvPipePkg::opImm: begin
                ctrlD.aluCtrl = aluF;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.regWrite = decode_i.funct3 inside {3'b000, 3'b110, 3'b111};
            end
            rvPipePkg::opLoad: begin
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.resultSrc = rvPipePkg::resMem;
                ctrlD.regWrite = (decode_i.funct3 == 3'b010);
            end
            rvPipePkg::opStore: begin
                ctrlD.aluSrcImm = 1'b1;
                immSrcD = rvPipePkg::immS;
            end
            rvPipePkg::opBranch: begin
                immSrcD = rvPipePkg::immB;
                ctrlD.aluCtrl = rvPipePkg::aluSub;
                ctrlD.isBranch = (decode_i.funct3[2:1] == 2'b00);
                ctrlD.bne = decode_i.funct3[0];
            end
            rvPipePkg::opJal: begin
                immSrcD = rvPipePkg::immJ;
                ctrlD.isJump = 1'b1;
                ctrlD.regWrite = 1'b1;
                ctrlD.resultSrc = rvPipePkg::resPcPlus4;
            end
            rvPipePkg::opJalr: begin
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.isJump = (decode_i.funct3 == 3'b000);
                ctrlD.regWrite = (decode_i.funct3 == 3'b000);
                ctrlD.resultSrc = rvPipePkg::resPcPlus4;
            end
            rvPipePkg::opLui: begin
                immSrcD = rvPipePkg::immU;
                ctrlD.regWrite = 1'b1;
                ctrlD.resultSrc = rvPipePkg::resImm;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || hazard_o.flushD) begin
            predD <= 1'b0;
        end else if (!hazard_o.stallD) begin
            predD <= predTakenD_i;
        end
        if (reset || hazard_o.flushE) begin
            ctrlE <= '0;
            predE <= 1'b0;
        end else begin
            ctrlE <= ctrlD;
            predE <= predD;
        end
        if (reset) begin
            regWriteM <= 1'b0;
            resultSrcM <= rvPipePkg::resAlu;
            regWriteW <= 1'b0;
            resultSrcW <= rvPipePkg::resAlu;
        end else begin
            regWriteM <= ctrlE.regWrite;
            resultSrcM <= ctrlE.resultSrc;
            regWriteW <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    // Redirect whenever the outcome disagrees with the fetch prediction.
    assign takenE = ctrlE.isJump || (ctrlE.isBranch && (zeroE_i ^ ctrlE.bne));
    assign pcSrcE = (ctrlE.isBranch || ctrlE.isJump) && (takenE != predE);

    assign loadUse = (ctrlE.resultSrc == rvPipePkg::resMem) && rdE_i != '0
                  && (rdE_i == decode_i.rs1 || rdE_i == decode_i.rs2);

    assign hazard_o.stallF = loadUse;
    assign hazard_o.stallD = loadUse;
    assign hazard_o.flushD = pcSrcE;
    assign hazard_o.flushE = pcSrcE || loadUse;
    assign hazard_o.forwardA = fwdSel(rs1E_i, rdM_i, regWriteM, rdW_i, regWriteW);
    assign hazard_o.forwardB = fwdSel(rs2E_i, rdM_i, regWriteM, rdW_i, regWriteW);

    assign ctrl_o.aluSrcImm = ctrlE.aluSrcImm;
    assign ctrl_o.aluCtrl = ctrlE.aluCtrl;
    assign ctrl_o.immSrc = immSrcD;
    assign ctrl_o.pcSrc = pcSrcE;
    assign ctrl_o.isBranch = ctrlE.isBranch;
    assign ctrl_o.isJump = ctrlE.isJump;
    assign ctrl_o.branchTaken = takenE;
    assign ctrl_o.resultSrcM = resultSrcM;
    assign ctrl_o.resultSrcW = resultSrcW;
    assign ctrl_o.regWriteW = regWriteW;

endmodule

//--- rtl/pipeDatapath.sv
`timescale 1ns/1ns

module pipeDatapath (
    input  logic                     clk,
    input  logic                     reset,
    input  rvPipePkg::word_t         instrF_i,
    output rvPipePkg::word_t         pcF_o,
    input  rvPipePkg::hazardCtrl_t   hazard_i,
    input  rvPipePkg::execCtrl_t     ctrl_i,
    output rvPipePkg::decodeFields_t decode_o,
    output rvPipePkg::regAddr_t      rs1E_o,
    output rvPipePkg::regAddr_t      rs2E_o,
    output rvPipePkg::regAddr_t      rdE_o,
    output rvPipePkg::regAddr_t      rdM_o,
    output rvPipePkg::regAddr_t      rdW_o,
    output logic                     zeroE_o,
    output rvPipePkg::memReq_t       dmemReq_o,
    input  rvPipePkg::word_t         dmemRdata_i,
    output rvPipePkg::retire_t       retire_o,
    output logic                     predTakenF_o
);

    rvPipePkg::word_t pcPlus4F, pcNextF, predTargetF, redirectE;
    rvPipePkg::phtIdx_t phtIdxF, phtIdxD, phtIdxE;
    rvPipePkg::word_t instrD, pcD, pcPlus4D, immD, rd1D, rd2D;
    logic storeD, storeE, storeM, jalrE;
    rvPipePkg::word_t rd1E, rd2E, pcE, pcPlus4E, immE;
    rvPipePkg::word_t srcAE, srcBE, writeDataE, aluResultE, targetE;
    rvPipePkg::word_t aluResultM, writeDataM, immM, pcPlus4M, fwdDataM;
    rvPipePkg::word_t aluResultW, readDataW, immW, pcPlus4W, resultW;

    // Fetch.
    assign pcPlus4F = pcF_o + 32'd4;
    assign pcNextF = ctrl_i.pcSrc ? redirectE : (predTakenF_o ? predTargetF : pcPlus4F);

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= rvPipePkg::pcStart;
        end else if (!hazard_i.stallF) begin
            pcF_o <= pcNextF;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || hazard_i.flushD) begin
            instrD <= '0; // Opcode zero is a no-op.
        end else if (!hazard_i.stallD) begin
            instrD <= instrF_i;
        end
        if (!hazard_i.stallD) begin
            pcD <= pcF_o;
            pcPlus4D <= pcPlus4F;
            phtIdxD <= phtIdxF;
        end
    end

    // Decode.
    assign decode_o = '{op: rvPipePkg::opcode_t'(instrD[6:0]), funct3: instrD[14:12],
                        funct7b5: instrD[30], rs1: instrD[19:15], rs2: instrD[24:20]};
    assign storeD = (decode_o.op == rvPipePkg::opStore) && (decode_o.funct3 == 3'b010);

    always_comb begin
        case (ctrl_i.immSrc)
            rvPipePkg::immS: immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            rvPipePkg::immB: immD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                     instrD[11:8], 1'b0};
            rvPipePkg::immJ: immD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                     instrD[30:21], 1'b0};
            rvPipePkg::immU: immD = {instrD[31:12], 12'b0};
            default:         immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    regFile rf (
        .clk(clk), .reset(reset),
        .ra1_i(decode_o.rs1), .ra2_i(decode_o.rs2),
        .rd1_o(rd1D), .rd2_o(rd2D),
        .we_i(ctrl_i.regWriteW), .wa_i(rdW_o), .wd_i(resultW)
    );

    always_ff @(posedge clk) begin
        if (reset || hazard_i.flushE) begin
            rs1E_o <= '0;
            rs2E_o <= '0;
            rdE_o <= '0;
            storeE <= 1'b0;
        end else begin
            rs1E_o <= decode_o.rs1;
            rs2E_o <= decode_o.rs2;
            rdE_o <= instrD[11:7];
            storeE <= storeD;
        end
        rd1E <= rd1D;
        rd2E <= rd2D;
        pcE <= pcD;
        pcPlus4E <= pcPlus4D;
        immE <= immD;
        phtIdxE <= phtIdxD;
    end

    // Execute.
    always_comb begin
        srcAE = (hazard_i.forwardA == rvPipePkg::fwdMem) ? fwdDataM
              : (hazard_i.forwardA == rvPipePkg::fwdWb) ? resultW : rd1E;
        writeDataE = (hazard_i.forwardB == rvPipePkg::fwdMem) ? fwdDataM
                   : (hazard_i.forwardB == rvPipePkg::fwdWb) ? resultW : rd2E;
    end
    assign srcBE = ctrl_i.aluSrcImm ? immE : writeDataE;

    aluUnit alu (
        .a_i(srcAE), .b_i(srcBE), .ctrl_i(ctrl_i.aluCtrl),
        .result_o(aluResultE), .zero_o(zeroE_o)
    );

    // Only jalr is a jump that takes its operand from the immediate.
    assign jalrE = ctrl_i.isJump && ctrl_i.aluSrcImm;
    assign targetE = jalrE ? {aluResultE[31:1], 1'b0} : pcE + immE;
    assign redirectE = ctrl_i.branchTaken ? targetE : pcPlus4E;

    branchPredictor bp (
        .clk(clk), .reset(reset),
        .pcF_i(pcF_o), .opF_i(rvPipePkg::opcode_t'(instrF_i[6:0])),
        .target_o(predTargetF), .taken_o(predTakenF_o), .readIdx_o(phtIdxF),
        .updateIdx_i(phtIdxE), .updateEn_i(ctrl_i.isBranch),
        .updateTaken_i(ctrl_i.branchTaken),
        .btbWe_i(ctrl_i.isJump || (ctrl_i.isBranch && ctrl_i.branchTaken)),
        .btbIdx_i(pcE), .btbTarget_i(targetE)
    );

    // Memory.
    always_ff @(posedge clk) begin
        if (reset) begin
            storeM <= 1'b0;
        end else begin
            storeM <= storeE;
        end
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        immM <= immE;
        pcPlus4M <= pcPlus4E;
        rdM_o <= rdE_o;
    end

    assign dmemReq_o = '{addr: aluResultM, wdata: writeDataM, we: storeM};

    always_comb begin
        case (ctrl_i.resultSrcM)
            rvPipePkg::resPcPlus4: fwdDataM = pcPlus4M;
            rvPipePkg::resImm:     fwdDataM = immM;
            default:               fwdDataM = aluResultM; // Loads stall instead.
        endcase
    end

    // Writeback.
    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW <= dmemRdata_i;
        immW <= immM;
        pcPlus4W <= pcPlus4M;
        rdW_o <= rdM_o;
    end

    always_comb begin
        case (ctrl_i.resultSrcW)
            rvPipePkg::resMem:     resultW = readDataW;
            rvPipePkg::resPcPlus4: resultW = pcPlus4W;
            rvPipePkg::resImm:     resultW = immW;
            default:               resultW = aluResultW;
        endcase
    end

    assign retire_o = '{valid: ctrl_i.regWriteW && rdW_o != '0, rd: rdW_o, data: resultW};

endmodule

//--- rtl/branchPredictor.sv
`timescale 1ns/1ns

module branchPredictor (
    input  logic                clk,
    input  logic                reset,
    input  rvPipePkg::word_t    pcF_i,
    input  rvPipePkg::opcode_t  opF_i,
    output rvPipePkg::word_t    target_o,
    output logic                taken_o,
    output rvPipePkg::phtIdx_t  readIdx_o,
    input  rvPipePkg::phtIdx_t  updateIdx_i,
    input  logic                updateEn_i,
    input  logic                updateTaken_i,
    input  logic                btbWe_i,
    input  rvPipePkg::word_t    btbIdx_i, // PC of the resolving instruction.
    input  rvPipePkg::word_t    btbTarget_i
);

    localparam int tagLsb = rvPipePkg::btbIdxBits + 2;

    logic [1:0] pht [2**rvPipePkg::ghrBits];
    rvPipePkg::phtIdx_t ghr;
    logic [rvPipePkg::btbEntries-1:0] btbValid;
    rvPipePkg::word_t btbTarget [rvPipePkg::btbEntries];
    logic [31:tagLsb] btbTag [rvPipePkg::btbEntries];
    rvPipePkg::btbIdx_t rdIdx;
    rvPipePkg::btbIdx_t wrIdx;
    logic hit;

    assign rdIdx = pcF_i[tagLsb-1:2];
    assign wrIdx = btbIdx_i[tagLsb-1:2];
    // Tag compare stops aliased entries from steering fetch.
    assign hit = btbValid[rdIdx] && (btbTag[rdIdx] == pcF_i[31:tagLsb]);
    assign readIdx_o = ghr ^ pcF_i[rvPipePkg::ghrBits+1:2];
    assign target_o = btbTarget[rdIdx];
    assign taken_o = hit && (opF_i == rvPipePkg::opJal
        || (opF_i == rvPipePkg::opBranch && pht[readIdx_o][1]));

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            btbValid <= '0;
            for (int i = 0; i < 2**rvPipePkg::ghrBits; i++) begin
                pht[i] <= 2'b01; // Weakly not-taken.
            end
        end else begin
            if (updateEn_i) begin
                ghr <= {ghr[rvPipePkg::ghrBits-2:0], updateTaken_i};
                if (updateTaken_i && pht[updateIdx_i] != 2'b11) begin
                    pht[updateIdx_i] <= pht[updateIdx_i] + 2'd1;
                end else if (!updateTaken_i && pht[updateIdx_i] != 2'b00) begin
                    pht[updateIdx_i] <= pht[updateIdx_i] - 2'd1;
                end
            end
            if (btbWe_i) begin
                btbValid[wrIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (btbWe_i) begin
            btbTarget[wrIdx] <= btbTarget_i;
            btbTag[wrIdx] <= btbIdx_i[31:tagLsb];
        end
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                clk,
    input  logic                reset,
    input  rvPipePkg::regAddr_t ra1_i,
    input  rvPipePkg::regAddr_t ra2_i,
    output rvPipePkg::word_t    rd1_o,
    output rvPipePkg::word_t    rd2_o,
    input  logic                we_i,
    input  rvPipePkg::regAddr_t wa_i,
    input  rvPipePkg::word_t    wd_i
);

    rvPipePkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // Write-through keeps writeback visible to decode in the same cycle.
    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule

//--- rtl/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  rvPipePkg::word_t    a_i,
    input  rvPipePkg::word_t    b_i,
    input  rvPipePkg::aluCtrl_t ctrl_i,
    output rvPipePkg::word_t    result_o,
    output logic                zero_o
);

    always_comb begin
        case (ctrl_i)
            rvPipePkg::aluSub: result_o = a_i - b_i;
            rvPipePkg::aluAnd: result_o = a_i & b_i;
            rvPipePkg::aluOr:  result_o = a_i | b_i;
            rvPipePkg::aluSlt: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            default:           result_o = a_i + b_i;
        endcase
    end

    // Branch compare relies on subtract.
    assign zero_o = (result_o == '0);

endmodule

//--- rtl/rvPipePkg.sv
package rvPipePkg;

    localparam int btbEntries = 16;
    localparam int ghrBits = 4;
    localparam int btbIdxBits = $clog2(btbEntries);

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [ghrBits-1:0] phtIdx_t;
    typedef logic [btbIdxBits-1:0] btbIdx_t;

    localparam word_t pcStart = 32'h0000_0000;

    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcode_t;

    typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSrc_t;
    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluCtrl_t;
    typedef enum logic [1:0] {fwdNone, fwdWb, fwdMem} fwdSel_t;
    typedef enum logic [1:0] {resAlu, resMem, resPcPlus4, resImm} resultSrc_t;

    typedef struct packed {
        opcode_t    op;
        logic [2:0] funct3;
        logic       funct7b5;
        regAddr_t   rs1;
        regAddr_t   rs2;
    } decodeFields_t;

    typedef struct packed {
        logic    stallF;
        logic    stallD;
        logic    flushD;
        logic    flushE;
        fwdSel_t forwardA;
        fwdSel_t forwardB;
    } hazardCtrl_t;

    typedef struct packed {
        logic       aluSrcImm;
        aluCtrl_t   aluCtrl;
        immSrc_t    immSrc;
        logic       pcSrc;
        logic       isBranch;
        logic       isJump;
        logic       branchTaken; // Resolved direction, 1 for jumps.
        resultSrc_t resultSrcM;
        resultSrc_t resultSrcW;
        logic       regWriteW;
    } execCtrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } memReq_t;

    typedef struct packed {
        logic     valid;
        regAddr_t rd;
        word_t    data;
    } retire_t;

endpackage
